//--- pg_fifo_trace.txt
# columns: opcode, value in hex, expected flags in hex before the line acts
# flags: bit 2 pwr_enable_b_out, bit 1 full, bit 0 empty; idle value 0 is a random gap
# after reset the array is off until the power chain drains
idle 2 7
idle 1 1
# five words in, then out in order, queue A1 A2 A3 A4 A5
push 5a5a5a5a5a5a01 1
push 5a5a5a5a5a5a02 0
push 5a5a5a5a5a5a03 0
push 5a5a5a5a5a5a04 0
push 5a5a5a5a5a5a05 0
pop 5a5a5a5a5a5a01 0
pop 5a5a5a5a5a5a02 0
pop 5a5a5a5a5a5a03 0
pop 5a5a5a5a5a5a04 0
pop 5a5a5a5a5a5a05 0
idle 0 1
# fill all eight rows, the ninth word is dropped, queue B1 to B8
push 3c3c3c3c3c3c01 1
push 3c3c3c3c3c3c02 0
push 3c3c3c3c3c3c03 0
push 3c3c3c3c3c3c04 0
push 3c3c3c3c3c3c05 0
push 3c3c3c3c3c3c06 0
push 3c3c3c3c3c3c07 0
push 3c3c3c3c3c3c08 0
push 3c3c3c3c3c3c09 2
pop 3c3c3c3c3c3c01 2
pop 3c3c3c3c3c3c02 0
pop 3c3c3c3c3c3c03 0
pop 3c3c3c3c3c3c04 0
pop 3c3c3c3c3c3c05 0
pop 3c3c3c3c3c3c06 0
pop 3c3c3c3c3c3c07 0
pop 3c3c3c3c3c3c08 0
# pop on an empty queue gives no valid
pop 00000000000000 1
idle 1 1
# power down while empty, push while off is lost
power 1 1
push 7fffffffffffff 7
idle 0 7
power 0 7
idle 1 1
# isolated pop reads zero but still consumes D1, queue D1 D2 D3
push 1234567890ab01 1
push 1234567890ab02 0
push 1234567890ab03 0
isolate 1 0
pop 00000000000000 0
idle 1 0
isolate 0 0
pop 1234567890ab02 0
pop 1234567890ab03 0
idle 0 1
# interleaved traffic, queue E1 E2 E3 E4
push 0f0f0f0f0f0f01 1
push 0f0f0f0f0f0f02 0
pop 0f0f0f0f0f0f01 0
push 0f0f0f0f0f0f03 0
pop 0f0f0f0f0f0f02 0
push 0f0f0f0f0f0f04 0
pop 0f0f0f0f0f0f03 0
pop 0f0f0f0f0f0f04 0
pop 00000000000000 1
idle 2 1

//--- src.f
+incdir+.
fifo_pkg.sv
mem_reset_sync.sv
rf_pg_8x55.sv
fifo_wr_ctl.sv
fifo_rd_ctl.sv
pg_fifo_top.sv
pg_fifo_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = pg_fifo_tb
FILELIST = src.f
OBJ_DIR  = obj_dir

SOURCES  = $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS  = fifo_macros.svh
TRACE    = pg_fifo_trace.txt
SIM_BIN  = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source, the header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The simulator exits non-zero on $fatal, so make fails with it
run: $(SIM_BIN) $(TRACE)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- pg_fifo_tb.sv
`timescale 1ns/1ps

module pg_fifo_tb;

    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 10;

    logic            clk;
    logic            rst_n;
    logic            push;
    fifo_pkg::data_t push_data;
    logic            full;
    logic            pop;
    logic            pop_valid;
    fifo_pkg::data_t pop_data;
    logic            empty;
    logic            pwr_enable_b;
    logic            isol_en;
    logic            pwr_enable_b_out;

    // Trace contents, one entry per command line of the file
    logic [63:0]     op_q[$];
    fifo_pkg::data_t val_q[$];
    logic [3:0]      exp_q[$];
    int              trace_len;
    logic            trace_ready;

    // A pop accepted in the previous cycle owes a word in this one
    logic            pending_pop;
    fifo_pkg::data_t pending_data;

    pg_fifo_top i_pg_fifo_top (
         .clk              (clk)
        ,.rst_n            (rst_n)
        ,.push             (push)
        ,.push_data        (push_data)
        ,.full             (full)
        ,.pop              (pop)
        ,.pop_valid        (pop_valid)
        ,.pop_data         (pop_data)
        ,.empty            (empty)
        ,.pwr_enable_b     (pwr_enable_b)
        ,.isol_en          (isol_en)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // --------------------------------------------------------------------------
    // Compare tasks
    // --------------------------------------------------------------------------

    task automatic check_data(input string name, input fifo_pkg::data_t expected,
                              input fifo_pkg::data_t actual);
        if (actual !== expected) begin
            $display("error %s expected 0x%h actual 0x%h", name, expected, actual);
            $display("Verification failed");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error %s expected 0x%h actual 0x%h", name, expected, actual);
            $display("Verification failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    // pop_valid must be high exactly when a pop was accepted one cycle back
    task automatic check_pop_result();
        check_flag("pop_valid", pending_pop, pop_valid);
        if (pending_pop) begin
            check_data("pop_data", pending_data, pop_data);
        end
        pending_pop = 1'b0;
    endtask

    // --------------------------------------------------------------------------
    // Trace handling
    // --------------------------------------------------------------------------

    task automatic load_trace();
        int              fd;
        int              n;
        logic [8*96-1:0] line_buf;
        logic [63:0]     op;
        fifo_pkg::data_t val;
        logic [3:0]      exp;
        fd = $fopen("pg_fifo_trace.txt", "r");
        if (fd == 0) begin
            $display("trace file pg_fifo_trace.txt could not be opened");
            $display("Verification failed");
            $fatal(1, "missing stimulus");
        end else begin
            while (!$feof(fd)) begin
                line_buf = '0;
                op = '0;
                n = $fgets(line_buf, fd);
                n = $sscanf(line_buf, "%s %h %h", op, val, exp);
                // Comment lines start with a lone hash, blank lines scan short
                if (n == 3 && op != "#") begin
                    if (op != "push" && op != "pop" && op != "power" &&
                        op != "isolate" && op != "idle") begin
                        $display("trace holds an unknown opcode");
                        $display("Verification failed");
                        $fatal(1, "bad trace");
                    end
                    op_q.push_back(op);
                    val_q.push_back(val);
                    exp_q.push_back(exp);
                end
            end
            $fclose(fd);
            trace_len = op_q.size();
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        push <= 1'b0;
        pop  <= 1'b0;
        @(negedge clk);
        check_pop_result();
    endtask

    // One trace line, flags in exp are those seen before the line takes effect
    // Bit 2 is pwr_enable_b_out, bit 1 full, bit 0 empty
    task automatic run_line(input logic [63:0] op, input fifo_pkg::data_t val,
                            input logic [3:0] exp);
        int unsigned extra;
        extra = 0;
        @(posedge clk);
        push <= (op == "push");
        pop  <= (op == "pop");
        if (op == "push") begin
            push_data <= val;
        end
        if (op == "power") begin
            pwr_enable_b <= val[0];
        end
        if (op == "isolate") begin
            isol_en <= val[0];
        end
        @(negedge clk);
        check_pop_result();
        check_flag("pwr_enable_b_out", exp[2], pwr_enable_b_out);
        check_flag("full", exp[1], full);
        check_flag("empty", exp[0], empty);
        // A pop on a non-empty queue is accepted and owes data next cycle
        pending_pop  = (op == "pop") && !exp[0];
        pending_data = val;
        if (op == "power") begin
            // The chain output holds its old level one more cycle, then follows
            idle_cycle();
            check_flag("pwr_enable_b_out", exp[2], pwr_enable_b_out);
            idle_cycle();
            check_flag("pwr_enable_b_out", val[0], pwr_enable_b_out);
            if (val[0]) begin
                check_flag("full", 1'b1, full);
            end
        end else if (op == "idle") begin
            // A zero count asks for a random gap
            if (val == '0) begin
                extra = $urandom_range(4, 1) - 1;
            end else begin
                extra = int'(val) - 1;
            end
            repeat (extra) idle_cycle();
        end
    endtask

    // --------------------------------------------------------------------------
    // Main sequence and watchdog
    // --------------------------------------------------------------------------

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        push         = 1'b0;
        push_data    = '0;
        pop          = 1'b0;
        pwr_enable_b = 1'b0;
        isol_en      = 1'b0;
        pending_pop  = 1'b0;
        pending_data = '0;
        trace_ready  = 1'b0;
        trace_len    = 0;
        void'($urandom(26151));
        load_trace();
        trace_ready  = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < trace_len; i++) begin
            run_line(op_q[i], val_q[i], exp_q[i]);
        end
        // Collect the word of a pop on the last line
        idle_cycle();
        if (trace_len == 0) begin
            $display("trace held no commands");
            $display("Verification failed");
            $fatal(1, "empty trace");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

    // Budget of twenty cycles per trace line on top of the reset time
    initial begin
        wait (trace_ready);
        #((trace_len * 20 + RESET_CYCLES) * CLK_PERIOD);
        $display("run did not finish within the time limit");
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- pg_fifo_top.sv
`timescale 1ns/1ps

module pg_fifo_top (
     input  logic            clk
    ,input  logic            rst_n

    // Producer
    ,input  logic            push
    ,input  fifo_pkg::data_t push_data
    ,output logic            full

    // Consumer
    ,input  logic            pop
    ,output logic            pop_valid
    ,output fifo_pkg::data_t pop_data
    ,output logic            empty

    // Power control
    ,input  logic            pwr_enable_b
    ,input  logic            isol_en
    ,output logic            pwr_enable_b_out
);

    // Array write path
    logic            we;
    fifo_pkg::addr_t waddr;
    fifo_pkg::data_t wdata;

    // Array read path
    logic            re;
    fifo_pkg::addr_t raddr;
    fifo_pkg::data_t rdata;

    // Pointers crossing between the two controllers
    fifo_pkg::ptr_t  wr_ptr;
    fifo_pkg::ptr_t  rd_ptr;

    // ---------------------------------------------------------------------------
    // Producer
    // ---------------------------------------------------------------------------

    // The array reports power through its active-low acknowledge
    fifo_wr_ctl i_fifo_wr_ctl (
         .clk       (clk)
        ,.rst_n     (rst_n)
        ,.push      (push)
        ,.push_data (push_data)
        ,.full      (full)
        ,.mem_on    (~pwr_enable_b_out)
        ,.we        (we)
        ,.waddr     (waddr)
        ,.wdata     (wdata)
        ,.rd_ptr    (rd_ptr)
        ,.wr_ptr    (wr_ptr)
    );

    // ---------------------------------------------------------------------------
    // Buffer
    // ---------------------------------------------------------------------------

    // Both array clocks come from the single system clock
    rf_pg_8x55 i_rf_pg_8x55 (
         .wclk             (clk)
        ,.rclk             (clk)
        ,.rst_n            (rst_n)
        ,.we               (we)
        ,.waddr            (waddr)
        ,.wdata            (wdata)
        ,.re               (re)
        ,.raddr            (raddr)
        ,.rdata            (rdata)
        ,.isol_en          (isol_en)
        ,.pwr_enable_b_in  (pwr_enable_b)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

    // ---------------------------------------------------------------------------
    // Consumer
    // ---------------------------------------------------------------------------

    fifo_rd_ctl i_fifo_rd_ctl (
         .clk       (clk)
        ,.rst_n     (rst_n)
        ,.pop       (pop)
        ,.empty     (empty)
        ,.pop_valid (pop_valid)
        ,.pop_data  (pop_data)
        ,.re        (re)
        ,.raddr     (raddr)
        ,.rdata     (rdata)
        ,.wr_ptr    (wr_ptr)
        ,.rd_ptr    (rd_ptr)
    );

endmodule

//--- fifo_rd_ctl.sv
`timescale 1ns/1ps

module fifo_rd_ctl (
     input  logic            clk
    ,input  logic            rst_n

    // Consumer side
    ,input  logic            pop
    ,output logic            empty
    ,output logic            pop_valid
    ,output fifo_pkg::data_t pop_data

    // Array read port
    ,output logic            re
    ,output fifo_pkg::addr_t raddr
    ,input  fifo_pkg::data_t rdata

    // Pointer exchange with the producer
    ,input  fifo_pkg::ptr_t  wr_ptr
    ,output fifo_pkg::ptr_t  rd_ptr
);

    localparam int unsigned AW = $bits(fifo_pkg::addr_t);

    // Matching pointers, wrap bit included, mean nothing is stored
    assign empty = (rd_ptr == wr_ptr);

    // A pop on an empty queue is simply ignored
    assign re    = pop && !empty;
    assign raddr = rd_ptr[AW-1:0];

    // Pointer moves on every accepted pop, the array read lands on the same edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (re) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Valid lines up with the registered array output one cycle later
    // Back-to-back pops keep it high for consecutive cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pop_valid <= 1'b0;
        end else begin
            pop_valid <= re;
        end
    end

    // The array holds the read word in its own output register
    assign pop_data = rdata;

    // -----------------------------------------------------------------------
    // Checks
    // -----------------------------------------------------------------------

    // Empty relies on the producer pointer only ever stepping forward by one row
    // A jump or a step back would make stored words vanish or reappear
    a_wr_ptr_steps : assert property (
        @(posedge clk) disable iff (!rst_n)
        (wr_ptr == $past(wr_ptr)) ||
        (wr_ptr == fifo_pkg::ptr_t'($past(wr_ptr) + 1'b1))
    );

endmodule

//--- fifo_wr_ctl.sv
`timescale 1ns/1ps

module fifo_wr_ctl (
     input  logic            clk
    ,input  logic            rst_n

    // Producer side
    ,input  logic            push
    ,input  fifo_pkg::data_t push_data
    ,output logic            full

    // Array write port
    ,input  logic            mem_on
    ,output logic            we
    ,output fifo_pkg::addr_t waddr
    ,output fifo_pkg::data_t wdata

    // Pointer exchange with the consumer
    ,input  fifo_pkg::ptr_t  rd_ptr
    ,output fifo_pkg::ptr_t  wr_ptr
);

    // Address bits of a pointer, the wrap bit sits just above them
    localparam int unsigned AW    = $bits(fifo_pkg::addr_t);
    localparam int unsigned DEPTH = 1 << AW;

    logic ptrs_full;

    // Same row but opposite lap means every entry is occupied
    assign ptrs_full = (wr_ptr == {~rd_ptr[AW], rd_ptr[AW-1:0]});

    // A powered-down array cannot take data, so it looks full to the producer
    assign full = ptrs_full || !mem_on;

    // An accepted push writes straight into the row under the write pointer
    assign we    = push && !full;
    assign waddr = wr_ptr[AW-1:0];
    assign wdata = push_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (we) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // -----------------------------------------------------------------------
    // Checks
    // -----------------------------------------------------------------------

    // Occupancy seen across both controllers never exceeds the array size
    a_no_overrun : assert property (
        @(posedge clk) disable iff (!rst_n)
        fifo_pkg::ptr_t'(wr_ptr - rd_ptr) <= DEPTH
    );

endmodule

//--- rf_pg_8x55.sv
`timescale 1ns/1ps
`include "fifo_macros.svh"

module rf_pg_8x55 (
     input  logic            wclk
    ,input  logic            rclk
    ,input  logic            rst_n

    // Write port
    ,input  logic            we
    ,input  fifo_pkg::addr_t waddr
    ,input  fifo_pkg::data_t wdata

    // Read port
    ,input  logic            re
    ,input  fifo_pkg::addr_t raddr
    ,output fifo_pkg::data_t rdata

    // Power interface
    ,input  logic            isol_en
    ,input  logic            pwr_enable_b_in
    ,output logic            pwr_enable_b_out
);

    // -----------------------------------------------------------------------
    // Array reset
    // -----------------------------------------------------------------------

    logic rst_n_sync;

    // The read output register is reset from a copy of rst_n released on rclk
    mem_reset_sync i_mem_reset_sync (
         .clk        (rclk)
        ,.rst_n      (rst_n)
        ,.rst_n_sync (rst_n_sync)
    );

    // -----------------------------------------------------------------------
    // Power-enable chain
    // -----------------------------------------------------------------------

    // Active-low enable ripples through the chain, one stage per cycle
    logic [`PWR_CHAIN_DLY-1:0] pwr_b_q;
    logic                      mem_pwr_on;

    // Out of reset the array is off until the enable has walked through
    always_ff @(posedge rclk or negedge rst_n) begin
        if (!rst_n) begin
            pwr_b_q <= '1;
        end else begin
            pwr_b_q <= {pwr_b_q[`PWR_CHAIN_DLY-2:0], pwr_enable_b_in};
        end
    end

    assign pwr_enable_b_out = pwr_b_q[`PWR_CHAIN_DLY-1];

    // The array counts as powered only once the chain output is low
    assign mem_pwr_on = ~pwr_enable_b_out;

    // -----------------------------------------------------------------------
    // Storage array
    // -----------------------------------------------------------------------

    fifo_pkg::data_t mem [`FIFO_DEPTH];
    fifo_pkg::data_t rdata_q;

    // Writes into an unpowered array are lost
    always_ff @(posedge wclk) begin
        if (we && mem_pwr_on) begin
            mem[waddr] <= wdata;
        end
    end

    // The read register captures the addressed word on the edge that sees re
    // While the array is off the sense path returns zeros
    always_ff @(posedge rclk or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            rdata_q <= '0;
        end else if (!mem_pwr_on) begin
            rdata_q <= '0;
        end else if (re) begin
            rdata_q <= mem[raddr];
        end
    end

    // Isolation clamps the data leaving the array to zero
    assign rdata = isol_en ? '0 : rdata_q;

    // -----------------------------------------------------------------------
    // Checks
    // -----------------------------------------------------------------------

    // The producer must hold off while the power chain reports the array off
    a_no_write_when_off : assert property (
        @(posedge wclk) disable iff (!rst_n)
        we |-> mem_pwr_on
    );

    // Write controls must be clean once reset is gone
    a_wr_known : assert property (
        @(posedge wclk) disable iff (!rst_n)
        !$isunknown({we, waddr})
    );

    // Read controls must be clean once reset is gone
    a_rd_known : assert property (
        @(posedge rclk) disable iff (!rst_n)
        !$isunknown({re, raddr})
    );

endmodule

//--- mem_reset_sync.sv
`timescale 1ns/1ps

module mem_reset_sync (
     input  logic clk
    ,input  logic rst_n
    ,output logic rst_n_sync
);

    // Two-stage shift register that carries the release edge of the reset
    // The first stage may go metastable when rst_n rises close to a clock
    // edge, the second stage gives it a full cycle to settle
    logic [1:0] sync_q;

    // Assertion is asynchronous so the array sees reset even with no clock
    // Release walks a constant one through both stages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], 1'b1};
        end
    end

    // Last stage drives the array reset
    assign rst_n_sync = sync_q[1];

endmodule

//--- fifo_pkg.sv
`include "fifo_macros.svh"

package fifo_pkg;

    // -----------------------------------------------------------------------
    // Payload and addressing types shared by the controllers and the array
    // -----------------------------------------------------------------------

    // One stored word as it is pushed and popped
    typedef logic [`FIFO_DW-1:0] data_t;

    // Row select into the register file
    typedef logic [`FIFO_AW-1:0] addr_t;

    // Queue pointer, one bit wider than the address
    // The extra top bit toggles on every wrap of the array, which lets the
    // controllers tell a full queue from an empty one when the low bits match
    typedef logic [`FIFO_AW:0] ptr_t;

endpackage

//--- fifo_macros.svh
`ifndef FIFO_MACROS_SVH
`define FIFO_MACROS_SVH

// ---------------------------------------------------------------------------
// Buffer geometry
// ---------------------------------------------------------------------------

// Number of entries held in the register file
`define FIFO_DEPTH 8

// Address width of the register file, log2 of the depth
`define FIFO_AW 3

// Payload width of one entry
`define FIFO_DW 55

// ---------------------------------------------------------------------------
// Power management
// ---------------------------------------------------------------------------

// Flop stages between the power-enable input and the power-enable output
// of the array, so the output acknowledges a request this many cycles later
`define PWR_CHAIN_DLY 2

`endif
